// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= datapath_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
INCS := $(shell grep '^+incdir+' $(FILELIST) | sed 's/^+incdir+//')
HDRS := $(foreach d,$(INCS),$(wildcard $(d)/*.svh))

.PHONY: all run clean

all: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/datapath_properties.sv ====
`default_nettype none

module datapath_properties (
  input wire logic             CLK,
  input wire logic             nRST,
  input wire cpu_pkg::dp_in_t  mem_in,
  input wire cpu_pkg::dp_out_t mem_out
);

  logic dreq;

  assign dreq = mem_out.dmem_ren || mem_out.dmem_wen;

  read_write_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_out.dmem_ren && mem_out.dmem_wen))
    else $error("data read and write requested together");

  // a waiting request keeps every output level
  stable_while_waiting: assert property (@(posedge CLK) disable iff (!nRST)
    (dreq && !mem_in.dhit) |=> $stable(mem_out))
    else $error("memory outputs moved while waiting for dhit");

  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    mem_out.halt |=> mem_out.halt)
    else $error("halt dropped before reset");

  quiet_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
    mem_out.halt |-> !dreq)
    else $error("data request after halt");

endmodule

bind datapath datapath_properties props (
  .CLK     (CLK),
  .nRST    (nRST),
  .mem_in  (mem_in),
  .mem_out (mem_out)
);

`default_nettype wire

// ==== sim/datapath_tb.sv ====
`default_nettype none
`include "cpu_config.svh"

module datapath_tb;

  localparam int PROG_MAX  = 32;
  localparam int NUM_TESTS = 5;
  localparam int LIMIT     = 200 * PROG_MAX * NUM_TESTS;

  logic             CLK, nRST, dhit, pending;
  cpu_pkg::word_t   dmem_load, imem_load;
  cpu_pkg::dp_in_t  mem_in;
  cpu_pkg::dp_out_t mem_out;

  cpu_pkg::word_t imem [256];
  cpu_pkg::word_t dmem [256];
  cpu_pkg::word_t model_mem [256];
  cpu_pkg::word_t prog [$];
  cpu_pkg::word_t got_addr [$], got_data [$], exp_addr [$], exp_data [$];
  logic [31:0]    rng_state, cycles;
  int             waits;

  tb_clock clock_gen (.CLK(CLK));

  datapath uut (
    .CLK     (CLK),
    .nRST    (nRST),
    .mem_in  (mem_in),
    .mem_out (mem_out)
  );

  assign imem_load = imem[mem_out.imem_addr[9:2]];
  assign mem_in = '{ihit: 1'b1, dhit: dhit, imem_load: imem_load, dmem_load: dmem_load};

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_halt(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // data memory with 0 to 3 wait states per request
  always @(negedge CLK) begin
    if (!nRST || dhit) begin
      dhit    <= 1'b0;
      pending = 1'b0;
    end
    if (nRST && (mem_out.dmem_ren || mem_out.dmem_wen) && !dhit) begin
      if (!pending) begin
        pending = 1'b1;
        rng_state = xorshift(rng_state);
        waits = rng_state % 4;
      end
      if (waits == 0) begin
        dhit <= 1'b1;
        if (mem_out.dmem_wen) begin
          dmem[mem_out.dmem_addr[9:2]] = mem_out.dmem_store;
          got_addr.push_back(mem_out.dmem_addr);
          got_data.push_back(mem_out.dmem_store);
        end else begin
          dmem_load <= dmem[mem_out.dmem_addr[9:2]];
        end
      end else begin
        waits = waits - 1;
      end
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      fail_run("timeout, the core never reached halt");
    end
  end

  function automatic cpu_pkg::word_t r_word(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic cpu_pkg::word_t i_word(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpu_pkg::word_t j_word(input logic [5:0] op, input int index);
    return {op, 26'(index)};
  endfunction

  task automatic emit(input cpu_pkg::word_t w);
    prog.push_back(w);
  endtask

  // instruction-level reference without delay slots
  task automatic model_run();
    logic [31:0] r [32];
    logic [31:0] pc, ins, npc, simm, zimm, a, b, ea;
    logic [4:0]  rd;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    pc = `CPU_PC_INIT;
    steps = 0;
    forever begin
      ins  = imem[pc[9:2]];
      npc  = pc + 4;
      simm = {{16{ins[15]}}, ins[15:0]};
      zimm = {16'h0, ins[15:0]};
      a    = r[ins[25:21]];
      b    = r[ins[20:16]];
      rd   = ins[15:11];
      ea   = a + simm;
      if (ins[31:26] == `CPU_HALT_OP) begin
        break;
      end
      case (ins[31:26])
        6'h00: begin
          case (ins[5:0])
            6'h00: r[rd] = b << ins[10:6];
            6'h02: r[rd] = b >> ins[10:6];
            6'h08: npc = a;
            6'h21: r[rd] = a + b;
            6'h23: r[rd] = a - b;
            6'h24: r[rd] = a & b;
            6'h25: r[rd] = a | b;
            6'h26: r[rd] = a ^ b;
            6'h27: r[rd] = ~(a | b);
            6'h2a: r[rd] = {31'd0, $signed(a) < $signed(b)};
            6'h2b: r[rd] = {31'd0, a < b};
            default: ;
          endcase
        end
        6'h02: npc = {npc[31:28], ins[25:0], 2'b00};
        6'h03: begin
          r[31] = npc;
          npc = {npc[31:28], ins[25:0], 2'b00};
        end
        6'h04: if (a == b) npc = npc + (simm << 2);
        6'h05: if (a != b) npc = npc + (simm << 2);
        6'h09: r[ins[20:16]] = a + simm;
        6'h0a: r[ins[20:16]] = {31'd0, $signed(a) < $signed(simm)};
        6'h0c: r[ins[20:16]] = a & zimm;
        6'h0d: r[ins[20:16]] = a | zimm;
        6'h0e: r[ins[20:16]] = a ^ zimm;
        6'h0f: r[ins[20:16]] = {ins[15:0], 16'h0};
        6'h23: r[ins[20:16]] = model_mem[ea[9:2]];
        6'h2b: begin
          model_mem[ea[9:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        default: ;
      endcase
      r[0] = '0;
      pc = npc;
      steps++;
      if (steps > 1000) begin
        fail_run("reference model did not reach halt");
      end
    end
  endtask

  task automatic pulse_reset();
    @(negedge CLK);
    nRST = 1'b0;
    repeat (3) @(negedge CLK);
    compare_word("imem_addr", mem_out.imem_addr, `CPU_PC_INIT);
    compare_halt("imem_ren", mem_out.imem_ren, 1'b1);
    compare_halt("dmem_ren", mem_out.dmem_ren, 1'b0);
    compare_halt("dmem_wen", mem_out.dmem_wen, 1'b0);
    compare_halt("halt", mem_out.halt, 1'b0);
    nRST = 1'b1;
  endtask

  // loads the program, runs both the core and the model, checks stores
  task automatic run_program(input string name);
    int stores;
    if (prog.size() > PROG_MAX) begin
      fail_run({"program too long in ", name});
    end
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : '0;
      dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_9e37);
      model_mem[i] = dmem[i];
    end
    got_addr.delete();
    got_data.delete();
    exp_addr.delete();
    exp_data.delete();
    model_run();
    pulse_reset();
    while (!mem_out.halt) begin
      @(negedge CLK);
    end
    repeat (20) @(negedge CLK);
    compare_halt("halt", mem_out.halt, 1'b1);
    compare_halt("imem_ren", mem_out.imem_ren, 1'b0);
    stores = got_addr.size();
    compare_word({name, " store count"}, stores, exp_addr.size());
    for (int i = 0; i < stores; i++) begin
      compare_word({name, " dmem_addr"}, got_addr[i], exp_addr[i]);
      compare_word({name, " dmem_store"}, got_data[i], exp_data[i]);
    end
    prog.delete();
  endtask

  task automatic test_alu_chain();
    emit(i_word(cpu_pkg::OP_ADDIU, 0, 1, 16'h1234));
    emit(i_word(cpu_pkg::OP_LUI, 0, 2, 16'h8765));
    emit(i_word(cpu_pkg::OP_ORI, 2, 2, 16'h4321));
    emit(r_word(cpu_pkg::FN_ADDU, 1, 2, 3, 0));
    emit(i_word(cpu_pkg::OP_SW, 0, 3, 16'h0000));
    emit(r_word(cpu_pkg::FN_SUBU, 3, 2, 4, 0));
    emit(r_word(cpu_pkg::FN_AND, 4, 3, 5, 0));
    emit(r_word(cpu_pkg::FN_OR, 5, 2, 6, 0));
    emit(r_word(cpu_pkg::FN_XOR, 6, 1, 7, 0));
    emit(r_word(cpu_pkg::FN_NOR, 7, 0, 8, 0));
    emit(i_word(cpu_pkg::OP_SW, 0, 8, 16'h0004));
    emit(r_word(cpu_pkg::FN_SLT, 2, 1, 9, 0));
    emit(r_word(cpu_pkg::FN_SLTU, 2, 9, 10, 0));
    emit(r_word(cpu_pkg::FN_SLL, 0, 1, 11, 4));
    emit(r_word(cpu_pkg::FN_SRL, 0, 11, 12, 3));
    emit(i_word(cpu_pkg::OP_SW, 0, 9, 16'h0008));
    emit(i_word(cpu_pkg::OP_SW, 0, 10, 16'h000c));
    emit(i_word(cpu_pkg::OP_SW, 0, 12, 16'h0010));
    emit(i_word(cpu_pkg::OP_ANDI, 8, 14, 16'hf0f0));
    emit(i_word(cpu_pkg::OP_XORI, 14, 15, 16'hffff));
    emit(i_word(cpu_pkg::OP_SLTI, 15, 16, 16'hffff));
    // r0 must stay zero
    emit(i_word(cpu_pkg::OP_ADDIU, 0, 0, 16'h0005));
    emit(r_word(cpu_pkg::FN_ADDU, 0, 16, 17, 0));
    emit(i_word(cpu_pkg::OP_SW, 0, 17, 16'h0014));
    emit(i_word(cpu_pkg::OP_SW, 0, 15, 16'h0018));
    emit(i_word(cpu_pkg::OP_SW, 0, 7, 16'h001c));
    emit({`CPU_HALT_OP, 26'd0});
    run_program("alu chain");
  endtask

  task automatic test_load_use();
    emit(i_word(cpu_pkg::OP_LW, 0, 1, 16'h0040));
    emit(r_word(cpu_pkg::FN_ADDU, 1, 1, 2, 0));
    emit(i_word(cpu_pkg::OP_SW, 0, 2, 16'h0000));
    emit(i_word(cpu_pkg::OP_LW, 0, 3, 16'h0044));
    emit(i_word(cpu_pkg::OP_SW, 0, 3, 16'h0004));
    emit(i_word(cpu_pkg::OP_LW, 0, 4, 16'h0000));
    emit(i_word(cpu_pkg::OP_ADDIU, 4, 5, 16'h0001));
    emit(i_word(cpu_pkg::OP_SW, 0, 5, 16'h0008));
    emit({`CPU_HALT_OP, 26'd0});
    run_program("load use");
  endtask

  task automatic test_branches();
    emit(i_word(cpu_pkg::OP_ADDIU, 0, 1, 16'h0005));
    emit(i_word(cpu_pkg::OP_ADDIU, 0, 2, 16'h0005));
    emit(i_word(cpu_pkg::OP_BEQ, 1, 2, 16'h0003));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0000));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0004));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0008));
    emit(i_word(cpu_pkg::OP_BNE, 1, 2, 16'h0003));
    emit(i_word(cpu_pkg::OP_SW, 0, 2, 16'h000c));
    emit(i_word(cpu_pkg::OP_BEQ, 1, 0, 16'h0001));
    emit(i_word(cpu_pkg::OP_SW, 0, 2, 16'h0010));
    emit(j_word(cpu_pkg::OP_J, 14));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0020));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0024));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0028));
    emit(i_word(cpu_pkg::OP_BNE, 1, 0, 16'h0001));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h002c));
    emit(i_word(cpu_pkg::OP_SW, 0, 2, 16'h0030));
    emit({`CPU_HALT_OP, 26'd0});
    run_program("branches");
  endtask

  task automatic test_call_return();
    emit(i_word(cpu_pkg::OP_ADDIU, 0, 1, 16'h0007));
    emit(j_word(cpu_pkg::OP_JAL, 5));
    emit(i_word(cpu_pkg::OP_SW, 0, 31, 16'h0000));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0004));
    emit({`CPU_HALT_OP, 26'd0});
    emit(i_word(cpu_pkg::OP_ADDIU, 1, 1, 16'h0001));
    emit(r_word(cpu_pkg::FN_JR, 31, 0, 0, 0));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0008));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h000c));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0010));
    run_program("call return");
  endtask

  task automatic test_halt();
    emit(i_word(cpu_pkg::OP_ADDIU, 0, 1, 16'h00aa));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0000));
    emit({`CPU_HALT_OP, 26'd0});
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0004));
    emit(i_word(cpu_pkg::OP_SW, 0, 1, 16'h0008));
    run_program("halt");
  endtask

  initial begin
    nRST      = 1'b0;
    dhit      = 1'b0;
    pending   = 1'b0;
    dmem_load = '0;
    waits     = 0;
    cycles    = '0;
    rng_state = 32'hfb52;
    test_alu_chain();
    test_load_use();
    test_branches();
    test_call_return();
    test_halt();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
  end

  // period of 4
  always #2 CLK = ~CLK;

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/forward_unit.sv
verilog/datapath.sv
sim/tb_clock.sv
sim/datapath_properties.sv
sim/datapath_tb.sv

// ==== verilog/alu.sv ====
`default_nettype none

module alu (
  input  wire cpu_pkg::aluop_t op,
  input  wire cpu_pkg::word_t  a,
  input  wire cpu_pkg::word_t  b,
  output cpu_pkg::word_t       result,
  output logic                 zero
);

  always_comb begin
    case (op)
      cpu_pkg::ALU_SLL:  result = a << b[4:0];
      cpu_pkg::ALU_SRL:  result = a >> b[4:0];
      cpu_pkg::ALU_ADD:  result = a + b;
      cpu_pkg::ALU_SUB:  result = a - b;
      cpu_pkg::ALU_AND:  result = a & b;
      cpu_pkg::ALU_OR:   result = a | b;
      cpu_pkg::ALU_XOR:  result = a ^ b;
      cpu_pkg::ALU_NOR:  result = ~(a | b);
      cpu_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      cpu_pkg::ALU_SLTU: result = {31'd0, a < b};
      default:           result = '0;
    endcase
  end

  // branches look at this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
`default_nettype none

module control_unit (
  input  wire cpu_pkg::word_t instr,
  output cpu_pkg::ctrl_t      ctrl
);

  cpu_pkg::r_t rtype;

  assign rtype = instr;

  always_comb begin
    ctrl = '0;
    case (rtype.opcode)
      cpu_pkg::OP_RTYPE: begin
        ctrl.reg_dst = cpu_pkg::RD_RD;
        ctrl.reg_wr  = 1'b1;
        case (rtype.funct)
          cpu_pkg::FN_SLL: begin
            ctrl.alu_op  = cpu_pkg::ALU_SLL;
            ctrl.alu_src = 1'b1;
            ctrl.imm_sel = cpu_pkg::IMM_SHAMT;
          end
          cpu_pkg::FN_SRL: begin
            ctrl.alu_op  = cpu_pkg::ALU_SRL;
            ctrl.alu_src = 1'b1;
            ctrl.imm_sel = cpu_pkg::IMM_SHAMT;
          end
          cpu_pkg::FN_JR: begin
            ctrl.reg_wr = 1'b0;
            ctrl.jreg   = 1'b1;
          end
          cpu_pkg::FN_ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::FN_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::FN_XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
          cpu_pkg::FN_NOR:  ctrl.alu_op = cpu_pkg::ALU_NOR;
          cpu_pkg::FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
          cpu_pkg::FN_SLTU: ctrl.alu_op = cpu_pkg::ALU_SLTU;
          default:          ctrl = '0;
        endcase
      end
      cpu_pkg::OP_J: ctrl.jump = 1'b1;
      cpu_pkg::OP_JAL: begin
        ctrl.jal     = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = cpu_pkg::RD_R31;
      end
      // branches compare rs and rt through a subtract
      cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
        ctrl.alu_op  = cpu_pkg::ALU_SUB;
        ctrl.imm_sel = cpu_pkg::IMM_SIGN;
        ctrl.beq     = (rtype.opcode == cpu_pkg::OP_BEQ);
        ctrl.bne     = (rtype.opcode == cpu_pkg::OP_BNE);
      end
      cpu_pkg::OP_ADDIU, cpu_pkg::OP_SLTI, cpu_pkg::OP_ANDI,
      cpu_pkg::OP_ORI, cpu_pkg::OP_XORI, cpu_pkg::OP_LUI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        case (rtype.opcode)
          cpu_pkg::OP_ADDIU: begin
            ctrl.alu_op  = cpu_pkg::ALU_ADD;
            ctrl.imm_sel = cpu_pkg::IMM_SIGN;
          end
          cpu_pkg::OP_SLTI: begin
            ctrl.alu_op  = cpu_pkg::ALU_SLT;
            ctrl.imm_sel = cpu_pkg::IMM_SIGN;
          end
          cpu_pkg::OP_ANDI: ctrl.alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OP_ORI:  ctrl.alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::OP_XORI: ctrl.alu_op = cpu_pkg::ALU_XOR;
          // lui ors the upper immediate into a zero operand
          default: begin
            ctrl.alu_op  = cpu_pkg::ALU_OR;
            ctrl.imm_sel = cpu_pkg::IMM_UPPER;
          end
        endcase
      end
      cpu_pkg::OP_LW, cpu_pkg::OP_SW: begin
        ctrl.alu_op     = cpu_pkg::ALU_ADD;
        ctrl.alu_src    = 1'b1;
        ctrl.imm_sel    = cpu_pkg::IMM_SIGN;
        ctrl.reg_wr     = (rtype.opcode == cpu_pkg::OP_LW);
        ctrl.mem_to_reg = (rtype.opcode == cpu_pkg::OP_LW);
        ctrl.mem_wr     = (rtype.opcode == cpu_pkg::OP_SW);
      end
      cpu_pkg::OP_HALT: ctrl.halt = 1'b1;
      default:          ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// program counter value after reset
`define CPU_PC_INIT 32'h0000_0000

// architectural registers, r0 reads as zero
`define CPU_REG_COUNT 32

// opcode that stops the core once it retires
`define CPU_HALT_OP 6'h3f

`endif

// ==== verilog/cpu_pkg.sv ====
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_XORI  = 6'h0e,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = `CPU_HALT_OP
  } opcode_t;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  // instruction formats
  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    regbits_t    rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } r_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm;
  } i_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr;
  } j_t;

  typedef enum logic [1:0] {RD_RT, RD_RD, RD_R31} regdst_t;
  typedef enum logic [1:0] {IMM_ZERO, IMM_SIGN, IMM_UPPER, IMM_SHAMT} immsel_t;
  typedef enum logic [1:0] {FWD_RF, FWD_WB, FWD_MEM, FWD_LOAD} fwd_sel_t;

  // all zero is a bubble
  typedef struct packed {
    aluop_t  alu_op;
    logic    alu_src;
    immsel_t imm_sel;
    regdst_t reg_dst;
    logic    reg_wr;
    logic    mem_to_reg;
    logic    mem_wr;
    logic    beq;
    logic    bne;
    logic    jump;
    logic    jal;
    logic    jreg;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    word_t imem_addr;
    logic  imem_ren;
    word_t dmem_addr;
    word_t dmem_store;
    logic  dmem_ren;
    logic  dmem_wen;
    logic  halt;
  } dp_out_t;

  typedef struct packed {
    logic  ihit;
    logic  dhit;
    word_t imem_load;
    word_t dmem_load;
  } dp_in_t;

  // pipeline registers
  typedef struct packed {
    word_t instr;
    word_t npc;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    npc;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    word_t    instr;
    regbits_t dest;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    npc;
    word_t    alu_out;
    logic     zero;
    word_t    store;
    word_t    target;
    regbits_t dest;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    npc;
    word_t    alu_out;
    word_t    load;
    regbits_t dest;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/datapath.sv ====
`default_nettype none
`include "cpu_config.svh"

module datapath (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire cpu_pkg::dp_in_t  mem_in,
  output cpu_pkg::dp_out_t      mem_out
);

  cpu_pkg::word_t    pc, pc_plus4, next_pc;
  cpu_pkg::if_id_t   if_id, if_id_next;
  cpu_pkg::id_ex_t   id_ex, id_ex_next;
  cpu_pkg::ex_mem_t  ex_mem, ex_mem_next;
  cpu_pkg::mem_wb_t  mem_wb, mem_wb_next;

  cpu_pkg::r_t       id_r, ex_r;
  cpu_pkg::i_t       id_i;
  cpu_pkg::j_t       ex_j;
  cpu_pkg::ctrl_t    id_ctrl;
  cpu_pkg::word_t    rf_rdat1, rf_rdat2, id_imm;
  cpu_pkg::regbits_t id_dest;

  cpu_pkg::fwd_sel_t fwd_a, fwd_b;
  cpu_pkg::word_t    op_rs, op_rt, alu_a, alu_b, alu_result;
  cpu_pkg::word_t    branch_addr, jump_addr, ex_target, wb_wdat;
  logic              alu_zero, mem_taken;
  logic              dmem_busy, advance, halting, halt_q;

  // fetch
  assign pc_plus4   = pc + 32'd4;
  assign if_id_next = '{instr: mem_in.imem_load, npc: pc_plus4};

  // decode
  assign id_r = if_id.instr;
  assign id_i = if_id.instr;

  control_unit u_control (
    .instr (if_id.instr),
    .ctrl  (id_ctrl)
  );

  register_file u_regs (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (mem_wb.ctrl.reg_wr),
    .wsel  (mem_wb.dest),
    .wdat  (wb_wdat),
    .rsel1 (id_r.rs),
    .rsel2 (id_r.rt),
    .rdat1 (rf_rdat1),
    .rdat2 (rf_rdat2)
  );

  always_comb begin
    case (id_ctrl.imm_sel)
      cpu_pkg::IMM_SIGN:  id_imm = {{16{id_i.imm[15]}}, id_i.imm};
      cpu_pkg::IMM_UPPER: id_imm = {id_i.imm, 16'h0000};
      cpu_pkg::IMM_SHAMT: id_imm = {27'd0, id_r.shamt};
      default:            id_imm = {16'h0000, id_i.imm};
    endcase
    case (id_ctrl.reg_dst)
      cpu_pkg::RD_RD:  id_dest = id_r.rd;
      cpu_pkg::RD_R31: id_dest = 5'd31;
      default:         id_dest = id_r.rt;
    endcase
  end

  assign id_ex_next = '{
    ctrl:  id_ctrl,
    npc:   if_id.npc,
    rdat1: rf_rdat1,
    rdat2: rf_rdat2,
    imm:   id_imm,
    instr: if_id.instr,
    dest:  id_dest
  };

  // execute
  assign ex_r = id_ex.instr;
  assign ex_j = id_ex.instr;

  forward_unit u_forward (
    .ex_rs      (ex_r.rs),
    .ex_rt      (ex_r.rt),
    .mem_dest   (ex_mem.dest),
    .wb_dest    (mem_wb.dest),
    .mem_reg_wr (ex_mem.ctrl.reg_wr),
    .mem_to_reg (ex_mem.ctrl.mem_to_reg),
    .wb_reg_wr  (mem_wb.ctrl.reg_wr),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b)
  );

  always_comb begin
    case (fwd_a)
      cpu_pkg::FWD_LOAD: op_rs = mem_in.dmem_load;
      cpu_pkg::FWD_MEM:  op_rs = ex_mem.alu_out;
      cpu_pkg::FWD_WB:   op_rs = wb_wdat;
      default:           op_rs = id_ex.rdat1;
    endcase
    case (fwd_b)
      cpu_pkg::FWD_LOAD: op_rt = mem_in.dmem_load;
      cpu_pkg::FWD_MEM:  op_rt = ex_mem.alu_out;
      cpu_pkg::FWD_WB:   op_rt = wb_wdat;
      default:           op_rt = id_ex.rdat2;
    endcase
    // shifts work on rt, lui on a zero operand
    case (id_ex.ctrl.imm_sel)
      cpu_pkg::IMM_SHAMT: alu_a = op_rt;
      cpu_pkg::IMM_UPPER: alu_a = '0;
      default:            alu_a = op_rs;
    endcase
  end

  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_rt;

  alu u_alu (
    .op     (id_ex.ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  assign branch_addr = id_ex.npc + {id_ex.imm[29:0], 2'b00};
  assign jump_addr   = {id_ex.npc[31:28], ex_j.addr, 2'b00};

  always_comb begin
    if (id_ex.ctrl.beq || id_ex.ctrl.bne) begin
      ex_target = branch_addr;
    end else if (id_ex.ctrl.jreg) begin
      ex_target = op_rs;
    end else begin
      ex_target = jump_addr;
    end
  end

  assign ex_mem_next = '{
    ctrl:    id_ex.ctrl,
    npc:     id_ex.npc,
    alu_out: alu_result,
    zero:    alu_zero,
    store:   op_rt,
    target:  ex_target,
    dest:    id_ex.dest
  };

  // memory, branches and jumps resolve here
  assign mem_taken = ex_mem.ctrl.jump || ex_mem.ctrl.jal || ex_mem.ctrl.jreg ||
                     (ex_mem.ctrl.beq && ex_mem.zero) ||
                     (ex_mem.ctrl.bne && !ex_mem.zero);

  assign mem_wb_next = '{
    ctrl:    ex_mem.ctrl,
    npc:     ex_mem.npc,
    alu_out: ex_mem.alu_out,
    load:    mem_in.dmem_load,
    dest:    ex_mem.dest
  };

  // writeback
  always_comb begin
    if (mem_wb.ctrl.jal) begin
      wb_wdat = mem_wb.npc;
    end else if (mem_wb.ctrl.mem_to_reg) begin
      wb_wdat = mem_wb.load;
    end else begin
      wb_wdat = mem_wb.alu_out;
    end
  end

  // hold everything while fetch misses or a data request waits
  assign dmem_busy = (ex_mem.ctrl.mem_to_reg || ex_mem.ctrl.mem_wr) && !mem_in.dhit;
  assign advance   = mem_in.ihit && !dmem_busy;

  // once a halt is decoded, fetch stops and only bubbles follow it
  assign halting = id_ctrl.halt || id_ex.ctrl.halt || ex_mem.ctrl.halt ||
                   mem_wb.ctrl.halt || halt_q;

  always_comb begin
    if (mem_taken) begin
      next_pc = ex_mem.target;
    end else if (halting) begin
      next_pc = pc;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc     <= `CPU_PC_INIT;
      if_id  <= '0;
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (advance) begin
      pc     <= next_pc;
      mem_wb <= mem_wb_next;
      if (mem_taken) begin
        // squash the three younger instructions
        if_id  <= '0;
        id_ex  <= '0;
        ex_mem <= '0;
      end else begin
        if_id  <= halting ? '0 : if_id_next;
        id_ex  <= id_ex_next;
        ex_mem <= ex_mem_next;
      end
    end
  end

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt_q <= 1'b0;
    end else if (mem_wb.ctrl.halt) begin
      halt_q <= 1'b1;
    end
  end

  always_comb begin
    mem_out.imem_addr  = pc;
    mem_out.imem_ren   = !halt_q;
    mem_out.dmem_addr  = ex_mem.alu_out;
    mem_out.dmem_store = ex_mem.store;
    mem_out.dmem_ren   = ex_mem.ctrl.mem_to_reg;
    mem_out.dmem_wen   = ex_mem.ctrl.mem_wr;
    mem_out.halt       = halt_q;
  end

endmodule

`default_nettype wire

// ==== verilog/forward_unit.sv ====
`default_nettype none

module forward_unit (
  input  wire cpu_pkg::regbits_t ex_rs,
  input  wire cpu_pkg::regbits_t ex_rt,
  input  wire cpu_pkg::regbits_t mem_dest,
  input  wire cpu_pkg::regbits_t wb_dest,
  input  wire logic              mem_reg_wr,
  input  wire logic              mem_to_reg,
  input  wire logic              wb_reg_wr,
  output cpu_pkg::fwd_sel_t      fwd_a,
  output cpu_pkg::fwd_sel_t      fwd_b
);

  // newest producer first, a mem-stage load comes off the bus
  function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::regbits_t src);
    if (src == '0) begin
      return cpu_pkg::FWD_RF;
    end
    if (mem_reg_wr && mem_dest == src) begin
      return mem_to_reg ? cpu_pkg::FWD_LOAD : cpu_pkg::FWD_MEM;
    end
    if (wb_reg_wr && wb_dest == src) begin
      return cpu_pkg::FWD_WB;
    end
    return cpu_pkg::FWD_RF;
  endfunction

  always_comb begin
    fwd_a = pick(ex_rs);
    fwd_b = pick(ex_rt);
  end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none
`include "cpu_config.svh"

module register_file (
  input  wire logic              CLK,
  input  wire logic              nRST,
  input  wire logic              wen,
  input  wire cpu_pkg::regbits_t wsel,
  input  wire cpu_pkg::word_t    wdat,
  input  wire cpu_pkg::regbits_t rsel1,
  input  wire cpu_pkg::regbits_t rsel2,
  output cpu_pkg::word_t         rdat1,
  output cpu_pkg::word_t         rdat2
);

  cpu_pkg::word_t regs [`CPU_REG_COUNT];
  logic           wr_live;

  // r0 is never written
  assign wr_live = wen && (wsel != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // same-cycle write shows through to decode
  assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire
